/* build.f */
+incdir+source
source/csr_pkg.sv
source/csr_decode.sv
source/csr_counter.sv
source/csr_machine_regs.sv
source/csr_result.sv
source/csr_top.sv
testbench/csr_sva.sv
testbench/csr_tb.sv

/* source/csr_counter.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inc,
    input  logic                    wr_lo,
    input  logic                    wr_hi,
    input  logic [`CSR_XLEN-1:0]    wdata,
    output logic [2*`CSR_XLEN-1:0]  count
);

    localparam int W = `CSR_XLEN;

    logic [2*W-1:0] count_next;

    assign count_next = count + (2*W)'(inc);

    // written word replaces its half of the incremented value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (wr_lo) begin
            count <= {count_next[2*W-1:W], wdata};
        end else if (wr_hi) begin
            count <= {wdata, count_next[W-1:0]};
        end else begin
            count <= count_next;
        end
    end

endmodule

/* source/csr_decode.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_decode import csr_pkg::*; (
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [`CSR_ID_W-1:0] paddr,
    input  logic                 exception_valid,
    input  priv_e                priv,
    input  logic                 mcounteren_cy,
    input  logic                 mcounteren_ir,
    output csr_sel_e             sel,
    output logic                 wr_en,
    output logic                 pslverr
);

    csr_sel_e dec_sel;
    logic     read_only;
    logic     user_ok;
    logic     legal;
    logic     access;

    always_comb begin
        dec_sel   = SEL_NONE;
        read_only = 1'b0;
        user_ok   = 1'b0;
        case (paddr)
            `CSR_MSTATUS:    dec_sel = SEL_MSTATUS;
            `CSR_MIE:        dec_sel = SEL_MIE;
            `CSR_MTVEC:      dec_sel = SEL_MTVEC;
            `CSR_MCOUNTEREN: dec_sel = SEL_MCOUNTEREN;
            `CSR_MSCRATCH:   dec_sel = SEL_MSCRATCH;
            `CSR_MEPC:       dec_sel = SEL_MEPC;
            `CSR_MCAUSE:     dec_sel = SEL_MCAUSE;
            `CSR_MTVAL:      dec_sel = SEL_MTVAL;
            `CSR_MCYCLE:     dec_sel = SEL_CYCLE_LO;
            `CSR_MCYCLEH:    dec_sel = SEL_CYCLE_HI;
            `CSR_MINSTRET:   dec_sel = SEL_INSTRET_LO;
            `CSR_MINSTRETH:  dec_sel = SEL_INSTRET_HI;
            `CSR_MISA: begin
                dec_sel   = SEL_MISA;
                read_only = 1'b1;
            end
            // user aliases, readable from u mode when enabled
            `CSR_CYCLE, `CSR_CYCLEH: begin
                dec_sel   = (paddr == `CSR_CYCLE) ? SEL_CYCLE_LO : SEL_CYCLE_HI;
                read_only = 1'b1;
                user_ok   = mcounteren_cy;
            end
            `CSR_INSTRET, `CSR_INSTRETH: begin
                dec_sel   = (paddr == `CSR_INSTRET) ? SEL_INSTRET_LO : SEL_INSTRET_HI;
                read_only = 1'b1;
                user_ok   = mcounteren_ir;
            end
            default: dec_sel = SEL_NONE;
        endcase
    end

    always_comb begin
        if (dec_sel == SEL_NONE)
            legal = 1'b0;
        else if (priv == PRIV_M)
            legal = !(pwrite && read_only);
        else
            legal = !pwrite && user_ok;
    end

    assign access  = psel && penable;
    assign pslverr = access && !legal;
    assign sel     = (access && legal) ? dec_sel : SEL_NONE;

    // a write racing an exception is dropped
    assign wr_en   = access && pwrite && legal && !exception_valid;

endmodule

/* source/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data and csr number widths
`define CSR_XLEN            32
`define CSR_ID_W            12

// machine mode csr numbers
`define CSR_MSTATUS         12'h300
`define CSR_MISA            12'h301
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305
`define CSR_MCOUNTEREN      12'h306
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342
`define CSR_MTVAL           12'h343
`define CSR_MCYCLE          12'hB00
`define CSR_MINSTRET        12'hB02
`define CSR_MCYCLEH         12'hB80
`define CSR_MINSTRETH       12'hB82

// user mode counter aliases
`define CSR_CYCLE           12'hC00
`define CSR_INSTRET         12'hC02
`define CSR_CYCLEH          12'hC80
`define CSR_INSTRETH        12'hC82

// mxl 32 with extensions a, i, m and u
`define CSR_MISA_VALUE      32'h4010_1101

// field positions
`define MSTATUS_MIE_BIT     3
`define MSTATUS_MPIE_BIT    7
`define MSTATUS_MPP_LSB     11
`define MIE_MTIE_BIT        7
`define MIE_MEIE_BIT        11
`define MCOUNTEREN_CY_BIT   0
`define MCOUNTEREN_IR_BIT   2

`endif

/* source/csr_machine_regs.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_machine_regs import csr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  csr_sel_e                sel,
    input  logic                    wr_en,
    input  logic [`CSR_XLEN-1:0]    pwdata,
    input  logic                    exception_valid,
    input  exception_e              exception_cause,
    input  logic [`CSR_XLEN-1:0]    exception_value,
    input  logic                    interrupt_valid,
    input  interrupt_e              interrupt_cause,
    input  logic                    mret,
    input  logic                    instr_done,
    input  logic [`CSR_XLEN-1:0]    pc,
    output priv_e                   priv,
    output logic                    mstatus_mie,
    output logic                    mstatus_mpie,
    output priv_e                   mstatus_mpp,
    output logic                    mie_meie,
    output logic                    mie_mtie,
    output logic [`CSR_XLEN-1:2]    mtvec_base,
    output mtvec_mode_e             mtvec_mode,
    output logic                    mcounteren_cy,
    output logic                    mcounteren_ir,
    output logic [`CSR_XLEN-1:0]    mscratch,
    output logic [`CSR_XLEN-1:0]    mepc,
    output logic [`CSR_XLEN-1:0]    mcause,
    output logic [`CSR_XLEN-1:0]    mtval,
    output logic [2*`CSR_XLEN-1:0]  mcycle,
    output logic [2*`CSR_XLEN-1:0]  minstret,
    output logic                    trap_taken,
    output logic                    mret_taken
);

    logic  wr_mstatus;
    logic  wr_mie;
    logic  wr_mtvec;
    logic  wr_mcounteren;
    logic  wr_mscratch;
    logic  wr_mepc;
    logic  wr_mcause;
    logic  wr_mtval;
    priv_e wr_mpp;
    logic  mpp_legal;
    logic  mode_legal;

    assign wr_mstatus    = wr_en && (sel == SEL_MSTATUS);
    assign wr_mie        = wr_en && (sel == SEL_MIE);
    assign wr_mtvec      = wr_en && (sel == SEL_MTVEC);
    assign wr_mcounteren = wr_en && (sel == SEL_MCOUNTEREN);
    assign wr_mscratch   = wr_en && (sel == SEL_MSCRATCH);
    assign wr_mepc       = wr_en && (sel == SEL_MEPC);
    assign wr_mcause     = wr_en && (sel == SEL_MCAUSE);
    assign wr_mtval      = wr_en && (sel == SEL_MTVAL);

    // warl fields keep their value on an illegal write
    assign wr_mpp     = priv_e'(pwdata[`MSTATUS_MPP_LSB +: 2]);
    assign mpp_legal  = (wr_mpp == PRIV_U) || (wr_mpp == PRIV_M);
    assign mode_legal = (pwdata[1:0] == MTVEC_DIRECT) || (pwdata[1:0] == MTVEC_VECTORED);

    assign trap_taken = exception_valid || interrupt_valid;
    assign mret_taken = mret && (priv == PRIV_M) && !trap_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            priv         <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= PRIV_U;
        end else if (trap_taken) begin
            priv         <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= mstatus_mie;
            mstatus_mpp  <= priv;
        end else if (mret_taken) begin
            priv         <= mstatus_mpp;
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= PRIV_U;
        end else if (wr_mstatus) begin
            mstatus_mie  <= pwdata[`MSTATUS_MIE_BIT];
            mstatus_mpie <= pwdata[`MSTATUS_MPIE_BIT];
            if (mpp_legal)
                mstatus_mpp <= wr_mpp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_meie      <= 1'b0;
            mie_mtie      <= 1'b0;
            mtvec_base    <= '0;
            mtvec_mode    <= MTVEC_DIRECT;
            mcounteren_cy <= 1'b0;
            mcounteren_ir <= 1'b0;
            mscratch      <= '0;
        end else begin
            if (wr_mie) begin
                mie_meie <= pwdata[`MIE_MEIE_BIT];
                mie_mtie <= pwdata[`MIE_MTIE_BIT];
            end
            if (wr_mtvec) begin
                mtvec_base <= pwdata[`CSR_XLEN-1:2];
                if (mode_legal)
                    mtvec_mode <= mtvec_mode_e'(pwdata[1:0]);
            end
            if (wr_mcounteren) begin
                mcounteren_cy <= pwdata[`MCOUNTEREN_CY_BIT];
                mcounteren_ir <= pwdata[`MCOUNTEREN_IR_BIT];
            end
            if (wr_mscratch)
                mscratch <= pwdata;
        end
    end

    // trap save registers, interrupt wins over exception
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (interrupt_valid) begin
            mepc   <= {pc[`CSR_XLEN-1:2], 2'b00};
            mcause <= {1'b1, {(`CSR_XLEN-6){1'b0}}, interrupt_cause};
            mtval  <= '0;
        end else if (exception_valid) begin
            mepc   <= {pc[`CSR_XLEN-1:2], 2'b00};
            mcause <= {{(`CSR_XLEN-5){1'b0}}, exception_cause};
            mtval  <= exception_value;
        end else begin
            if (wr_mepc)
                mepc <= {pwdata[`CSR_XLEN-1:2], 2'b00};
            if (wr_mcause)
                mcause <= pwdata;
            if (wr_mtval)
                mtval <= pwdata;
        end
    end

    csr_counter u_mcycle (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (1'b1),
        .wr_lo (wr_en && (sel == SEL_CYCLE_LO)),
        .wr_hi (wr_en && (sel == SEL_CYCLE_HI)),
        .wdata (pwdata),
        .count (mcycle)
    );

    // retired only when the instruction did not fault
    csr_counter u_minstret (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (instr_done && !exception_valid),
        .wr_lo (wr_en && (sel == SEL_INSTRET_LO)),
        .wr_hi (wr_en && (sel == SEL_INSTRET_HI)),
        .wdata (pwdata),
        .count (minstret)
    );

endmodule

/* source/csr_pkg.sv */
package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'b00,
        MTVEC_VECTORED = 2'b01
    } mtvec_mode_e;

    // synchronous exception codes, mcause bit 31 clear
    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED = 5'd0,
        EXC_INSTR_ACCESS     = 5'd1,
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_LOAD_ACCESS      = 5'd5,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_STORE_ACCESS     = 5'd7,
        EXC_ECALL_U          = 5'd8,
        EXC_ECALL_M          = 5'd11
    } exception_e;

    // interrupt codes, mcause bit 31 set
    typedef enum logic [4:0] {
        INT_M_SOFT  = 5'd3,
        INT_M_TIMER = 5'd7,
        INT_M_EXT   = 5'd11
    } interrupt_e;

    typedef enum logic [3:0] {
        SEL_NONE, SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC,
        SEL_MCOUNTEREN, SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL,
        SEL_CYCLE_LO, SEL_CYCLE_HI, SEL_INSTRET_LO, SEL_INSTRET_HI
    } csr_sel_e;

endpackage

/* source/csr_result.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_result import csr_pkg::*; (
    input  csr_sel_e                sel,
    input  logic                    mstatus_mie,
    input  logic                    mstatus_mpie,
    input  priv_e                   mstatus_mpp,
    input  logic                    mie_meie,
    input  logic                    mie_mtie,
    input  logic [`CSR_XLEN-1:2]    mtvec_base,
    input  mtvec_mode_e             mtvec_mode,
    input  logic                    mcounteren_cy,
    input  logic                    mcounteren_ir,
    input  logic [`CSR_XLEN-1:0]    mscratch,
    input  logic [`CSR_XLEN-1:0]    mepc,
    input  logic [`CSR_XLEN-1:0]    mcause,
    input  logic [`CSR_XLEN-1:0]    mtval,
    input  logic [2*`CSR_XLEN-1:0]  mcycle,
    input  logic [2*`CSR_XLEN-1:0]  minstret,
    input  logic                    interrupt_valid,
    input  interrupt_e              interrupt_cause,
    input  logic                    trap_taken,
    input  logic                    mret_taken,
    output logic [`CSR_XLEN-1:0]    prdata,
    output logic                    pc_redirect_valid,
    output logic [`CSR_XLEN-1:0]    pc_redirect
);

    localparam int W      = `CSR_XLEN;
    localparam int BASE_W = `CSR_XLEN - 2;

    logic [W-1:0]      rd_mstatus;
    logic [W-1:0]      rd_mie;
    logic [W-1:0]      rd_mcounteren;
    logic [BASE_W-1:0] vec_offset;

    always_comb begin
        rd_mstatus = '0;
        rd_mstatus[`MSTATUS_MIE_BIT]        = mstatus_mie;
        rd_mstatus[`MSTATUS_MPIE_BIT]       = mstatus_mpie;
        rd_mstatus[`MSTATUS_MPP_LSB +: 2]   = mstatus_mpp;
        rd_mie = '0;
        rd_mie[`MIE_MEIE_BIT]               = mie_meie;
        rd_mie[`MIE_MTIE_BIT]               = mie_mtie;
        rd_mcounteren = '0;
        rd_mcounteren[`MCOUNTEREN_CY_BIT]   = mcounteren_cy;
        rd_mcounteren[`MCOUNTEREN_IR_BIT]   = mcounteren_ir;
    end

    always_comb begin
        case (sel)
            SEL_MSTATUS:    prdata = rd_mstatus;
            SEL_MISA:       prdata = `CSR_MISA_VALUE;
            SEL_MIE:        prdata = rd_mie;
            SEL_MTVEC:      prdata = {mtvec_base, mtvec_mode};
            SEL_MCOUNTEREN: prdata = rd_mcounteren;
            SEL_MSCRATCH:   prdata = mscratch;
            SEL_MEPC:       prdata = mepc;
            SEL_MCAUSE:     prdata = mcause;
            SEL_MTVAL:      prdata = mtval;
            SEL_CYCLE_LO:   prdata = mcycle[W-1:0];
            SEL_CYCLE_HI:   prdata = mcycle[2*W-1:W];
            SEL_INSTRET_LO: prdata = minstret[W-1:0];
            SEL_INSTRET_HI: prdata = minstret[2*W-1:W];
            default:        prdata = '0;
        endcase
    end

    // exceptions always land on the base, even in vectored mode
    assign vec_offset = (interrupt_valid && mtvec_mode == MTVEC_VECTORED) ?
                        BASE_W'(interrupt_cause) : '0;

    assign pc_redirect_valid = trap_taken || mret_taken;

    always_comb begin
        if (trap_taken)
            pc_redirect = {mtvec_base + vec_offset, 2'b00};
        else if (mret_taken)
            pc_redirect = mepc;
        else
            pc_redirect = '0;
    end

endmodule

/* source/csr_top.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_top import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [`CSR_ID_W-1:0] paddr,
    input  logic [`CSR_XLEN-1:0] pwdata,
    output logic [`CSR_XLEN-1:0] prdata,
    output logic                 pslverr,
    input  logic                 exception_valid,
    input  exception_e           exception_cause,
    input  logic [`CSR_XLEN-1:0] exception_value,
    input  logic                 interrupt_valid,
    input  interrupt_e           interrupt_cause,
    input  logic                 mret,
    input  logic                 instr_done,
    input  logic [`CSR_XLEN-1:0] pc,
    output priv_e                priv,
    output logic                 pc_redirect_valid,
    output logic [`CSR_XLEN-1:0] pc_redirect,
    output logic                 mstatus_mie,
    output logic                 mie_meie,
    output logic                 mie_mtie
);

    csr_sel_e                sel;
    logic                    wr_en;
    logic                    mstatus_mpie;
    priv_e                   mstatus_mpp;
    logic [`CSR_XLEN-1:2]    mtvec_base;
    mtvec_mode_e             mtvec_mode;
    logic                    mcounteren_cy;
    logic                    mcounteren_ir;
    logic [`CSR_XLEN-1:0]    mscratch;
    logic [`CSR_XLEN-1:0]    mepc;
    logic [`CSR_XLEN-1:0]    mcause;
    logic [`CSR_XLEN-1:0]    mtval;
    logic [2*`CSR_XLEN-1:0]  mcycle;
    logic [2*`CSR_XLEN-1:0]  minstret;
    logic                    trap_taken;
    logic                    mret_taken;

    csr_decode i_decode (
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .exception_valid (exception_valid),
        .priv            (priv),
        .mcounteren_cy   (mcounteren_cy),
        .mcounteren_ir   (mcounteren_ir),
        .sel             (sel),
        .wr_en           (wr_en),
        .pslverr         (pslverr)
    );

    csr_machine_regs i_regs (.*);

    csr_result i_result (
        .sel               (sel),
        .mstatus_mie       (mstatus_mie),
        .mstatus_mpie      (mstatus_mpie),
        .mstatus_mpp       (mstatus_mpp),
        .mie_meie          (mie_meie),
        .mie_mtie          (mie_mtie),
        .mtvec_base        (mtvec_base),
        .mtvec_mode        (mtvec_mode),
        .mcounteren_cy     (mcounteren_cy),
        .mcounteren_ir     (mcounteren_ir),
        .mscratch          (mscratch),
        .mepc              (mepc),
        .mcause            (mcause),
        .mtval             (mtval),
        .mcycle            (mcycle),
        .minstret          (minstret),
        .interrupt_valid   (interrupt_valid),
        .interrupt_cause   (interrupt_cause),
        .trap_taken        (trap_taken),
        .mret_taken        (mret_taken),
        .prdata            (prdata),
        .pc_redirect_valid (pc_redirect_valid),
        .pc_redirect       (pc_redirect)
    );

endmodule

/* testbench/csr_stim.txt */
# op csr data expected name; W write (expected pslverr), R read, E read with pslverr, S random
# I irq / X exception (data pc), M mret (data 1 wants redirect), N retire, C cycle delta
R 300 0 00000080 rst_mstatus
R 301 0 40101101 rst_misa
R 305 0 00000000 rst_mtvec
R 341 0 00000000 rst_mepc
R 342 0 00000000 rst_mcause
R 340 0 00000000 rst_mscratch
S 340 0 00000000 mscratch_random
W 304 ffffffff 0 mie_write
R 304 0 00000880 mie_readback
W 305 00001001 0 mtvec_vectored
R 305 0 00001001 mtvec_vectored_read
W 305 00002002 0 mtvec_mode2_write
R 305 0 00002001 mtvec_mode2_read
W 300 00001888 0 mstatus_write
W 300 00000888 0 mstatus_mpp1_write
R 300 0 00001888 mstatus_mpp1_read
I 007 00000400 0000201c irq_vectored
R 341 0 00000400 irq_mepc
R 342 0 80000007 irq_mcause
R 343 0 00000000 irq_mtval
R 300 0 00001880 irq_mstatus
X 002 00000500 00002000 exc_vectored
R 342 0 00000002 exc_mcause
R 343 0 05000000 exc_mtval
R 300 0 00001800 exc_mstatus
W 305 00003000 0 mtvec_direct
I 00b 00000600 00003000 irq_direct
W 300 00000080 0 mpp_user_write
W 341 00000800 0 mepc_write
M 000 1 00000800 mret_to_user
W 340 12345678 1 user_write_denied
E 340 0 00000000 user_mscratch_denied
E c00 0 00000000 user_cycle_denied
M 000 0 00000000 user_mret_ignored
X 008 00000900 00003000 ecall_from_user
W 306 00000001 0 mcounteren_cy_write
M 000 1 00000900 mret_again
C c00 00000005 00000005 user_cycle_delta
E c02 0 00000000 user_instret_denied
I 003 00000a00 00003000 irq_return
R 342 0 80000003 irq_return_mcause
C b00 00000004 00000004 mcycle_delta
W b80 00000005 0 mcycleh_write
R b80 0 00000005 mcycleh_read
N 006 00000002 0 retire_pulses
R b02 0 00000004 minstret_read
R b82 0 00000000 minstreth_read

/* testbench/csr_sva.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_sva import csr_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 psel,
    input logic                 penable,
    input logic                 pslverr,
    input logic [`CSR_XLEN-1:0] prdata,
    input logic                 exception_valid,
    input logic                 interrupt_valid,
    input logic                 mret,
    input logic                 trap_taken,
    input priv_e                priv,
    input logic                 pc_redirect_valid
);

    int unsigned fail_count = 0;

    // an error access reads as zero
    a_slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable && prdata == '0))
    else begin
        fail_count++;
        $error("pslverr outside an apb access phase or with nonzero prdata");
    end

    a_priv_after_trap: assert property (@(posedge clk) disable iff (!rst_n)
        trap_taken |=> (priv == PRIV_M))
    else begin
        fail_count++;
        $error("priv is not M the cycle after a trap");
    end

    // redirect needs a trap, or an mret issued from m mode
    a_redirect_cause: assert property (@(posedge clk) disable iff (!rst_n)
        pc_redirect_valid |-> (exception_valid || interrupt_valid ||
                               (mret && priv == PRIV_M)))
    else begin
        fail_count++;
        $error("pc_redirect_valid without a trap or an m mode mret");
    end

endmodule

bind csr_top csr_sva i_sva (
    .clk               (clk),
    .rst_n             (rst_n),
    .psel              (psel),
    .penable           (penable),
    .pslverr           (pslverr),
    .prdata            (prdata),
    .exception_valid   (exception_valid),
    .interrupt_valid   (interrupt_valid),
    .mret              (mret),
    .trap_taken        (trap_taken),
    .priv              (priv),
    .pc_redirect_valid (pc_redirect_valid)
);

/* testbench/csr_tb.sv */
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_tb import csr_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
    localparam int POLL_LIMIT   = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [`CSR_ID_W-1:0] paddr;
    logic [`CSR_XLEN-1:0] pwdata;
    logic [`CSR_XLEN-1:0] prdata;
    logic                 pslverr;
    logic                 exception_valid;
    exception_e           exception_cause;
    logic [`CSR_XLEN-1:0] exception_value;
    logic                 interrupt_valid;
    interrupt_e           interrupt_cause;
    logic                 mret;
    logic                 instr_done;
    logic [`CSR_XLEN-1:0] pc;
    priv_e                priv;
    logic                 pc_redirect_valid;
    logic [`CSR_XLEN-1:0] pc_redirect;
    logic                 mstatus_mie;
    logic                 mie_meie;
    logic                 mie_mtie;

    int                   seed;
    int                   errors;
    int                   tests;
    int                   failed_tests;
    logic [`CSR_XLEN-1:0] rd_data;
    logic                 rd_err;
    logic [`CSR_XLEN-1:0] redirect;
    logic                 redirect_seen;

    csr_top i_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // each task starts and ends just after a falling edge
    task automatic apb_access(input logic write, input logic [`CSR_ID_W-1:0] addr,
                              input logic [`CSR_XLEN-1:0] wdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(SAMPLE_DELAY);
        rd_data = prdata;
        rd_err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_redirect();
        int polls;
        polls         = 0;
        redirect_seen = 1'b0;
        while (!redirect_seen && polls < POLL_LIMIT) begin
            #1;
            polls++;
            redirect_seen = pc_redirect_valid;
        end
        if (!redirect_seen) begin
            $display("timed out waiting for pc_redirect_valid");
            errors++;
        end
        redirect = pc_redirect;
    endtask

    task automatic pulse_trap(input logic is_irq, input logic [4:0] cause,
                              input logic [`CSR_XLEN-1:0] pc_val);
        pc = pc_val;
        if (is_irq) begin
            interrupt_valid = 1'b1;
            interrupt_cause = interrupt_e'(cause);
        end else begin
            exception_valid = 1'b1;
            exception_cause = exception_e'(cause);
            // fault value is the pc with its halves swapped
            exception_value = {pc_val[15:0], pc_val[31:16]};
        end
        wait_redirect();
        @(negedge clk);
        interrupt_valid = 1'b0;
        exception_valid = 1'b0;
    endtask

    task automatic retire(input int count, input int faulting);
        for (int i = 0; i < count; i++) begin
            instr_done      = 1'b1;
            exception_valid = (i < faulting);
            exception_cause = EXC_ILLEGAL_INSTR;
            @(negedge clk);
            instr_done      = 1'b0;
            exception_valid = 1'b0;
        end
    endtask

    task automatic run_step(input string op, input logic [`CSR_XLEN-1:0] csr,
                            input logic [`CSR_XLEN-1:0] data,
                            input logic [`CSR_XLEN-1:0] expected, input string name);
        int                   err_before;
        logic [`CSR_XLEN-1:0] first;
        logic [`CSR_XLEN-1:0] wdata;
        err_before = errors;
        tests++;
        case (op)
            "W": begin
                apb_access(1'b1, csr[`CSR_ID_W-1:0], data);
                if (rd_err !== expected[0]) begin
                    $display("ERROR %s: expected pslverr %b, actual %b", name, expected[0], rd_err);
                    errors++;
                end
            end
            "R", "E": begin
                apb_access(1'b0, csr[`CSR_ID_W-1:0], '0);
                if (rd_err !== (op == "E")) begin
                    $display("ERROR %s: expected pslverr %b, actual %b", name, op == "E", rd_err);
                    errors++;
                end
                if (rd_data !== expected) begin
                    $display("ERROR %s: expected %h, actual %h", name, expected, rd_data);
                    errors++;
                end
                // config outputs follow the register fields
                if (op == "R" && csr[`CSR_ID_W-1:0] == `CSR_MSTATUS &&
                    mstatus_mie !== expected[`MSTATUS_MIE_BIT]) begin
                    $display("ERROR %s: expected mstatus_mie %b, actual %b", name,
                             expected[`MSTATUS_MIE_BIT], mstatus_mie);
                    errors++;
                end
                if (op == "R" && csr[`CSR_ID_W-1:0] == `CSR_MIE &&
                    {mie_meie, mie_mtie} !==
                    {expected[`MIE_MEIE_BIT], expected[`MIE_MTIE_BIT]}) begin
                    $display("ERROR %s: expected meie/mtie %b%b, actual %b%b", name,
                             expected[`MIE_MEIE_BIT], expected[`MIE_MTIE_BIT],
                             mie_meie, mie_mtie);
                    errors++;
                end
            end
            "S": begin
                wdata = $random(seed);
                apb_access(1'b1, csr[`CSR_ID_W-1:0], wdata);
                apb_access(1'b0, csr[`CSR_ID_W-1:0], '0);
                if (rd_data !== wdata) begin
                    $display("ERROR %s: expected %h, actual %h", name, wdata, rd_data);
                    errors++;
                end
            end
            "I", "X": begin
                pulse_trap(op == "I", csr[4:0], data);
                if (redirect !== expected) begin
                    $display("ERROR %s: expected %h, actual %h", name, expected, redirect);
                    errors++;
                end
                if (priv !== PRIV_M) begin
                    $display("ERROR %s: expected priv %b, actual %b", name, PRIV_M, priv);
                    errors++;
                end
            end
            // data bit 0 asks for a redirect, bits 2:1 hold the privilege after
            "M": begin
                mret = 1'b1;
                if (data[0]) begin
                    wait_redirect();
                    if (redirect !== expected) begin
                        $display("ERROR %s: expected %h, actual %h", name, expected, redirect);
                        errors++;
                    end
                end else begin
                    #(SAMPLE_DELAY);
                    if (pc_redirect_valid !== 1'b0) begin
                        $display("ERROR %s: expected redirect 0, actual %b", name,
                                 pc_redirect_valid);
                        errors++;
                    end
                end
                @(negedge clk);
                mret = 1'b0;
                if (priv !== priv_e'(data[2:1])) begin
                    $display("ERROR %s: expected priv %b, actual %b", name, data[2:1], priv);
                    errors++;
                end
            end
            "N": retire(csr, data);
            "C": begin
                // setup phases of the two reads lie data cycles apart
                apb_access(1'b0, csr[`CSR_ID_W-1:0], '0);
                first = rd_data;
                repeat (data - 2) @(negedge clk);
                apb_access(1'b0, csr[`CSR_ID_W-1:0], '0);
                if (rd_err !== 1'b0 || rd_data - first !== expected) begin
                    $display("ERROR %s: expected %h, actual %h", name, expected, rd_data - first);
                    errors++;
                end
            end
            default: begin
                $display("unknown stimulus operation %s in step %s", op, name);
                errors++;
            end
        endcase
        if (errors == err_before) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s", name);
            failed_tests++;
        end
    endtask

    initial begin
        int                   fd;
        int                   n;
        string                line;
        string                op;
        string                name;
        logic [`CSR_XLEN-1:0] csr;
        logic [`CSR_XLEN-1:0] data;
        logic [`CSR_XLEN-1:0] expected;
        seed            = 32'h867c;
        errors          = 0;
        tests           = 0;
        failed_tests    = 0;
        rst_n           = 1'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        exception_valid = 1'b0;
        exception_cause = EXC_INSTR_MISALIGNED;
        exception_value = '0;
        interrupt_valid = 1'b0;
        interrupt_cause = INT_M_SOFT;
        mret            = 1'b0;
        instr_done      = 1'b0;
        pc              = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        fd = $fopen("testbench/csr_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/csr_stim.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %s", op, csr, data, expected, name);
                if (n != 5) begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                end else begin
                    run_step(op, csr, data, expected, name);
                end
            end
            $fclose(fd);
        end
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests, failed_tests, errors, i_dut.i_sva.fail_count);
        if (errors == 0 && i_dut.i_sva.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
